// ==== all.f ====
spw_char_pkg.sv
spw_token_pkg.sv
ds_bit_recovery.sv
char_framer.sv
char_parity_check.sv
token_classifier.sv
token_info_pack.sv
spw_token_detector.sv
spw_token_detector_chk.sv
tb_spw_token_detector.sv

// ==== tb_spw_token_detector.sv ====
// Directed testbench for the SpaceWire token detector
// Clock and reset, data-strobe encoder tasks, reference model
// with an expected-info queue, directed tests and a watchdog

`timescale 1ns/1ps

module tb_spw_token_detector;

	import spw_char_pkg::*;
	import spw_token_pkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int BIT_CYCLES    = 3;
	localparam int RESET_CYCLES  = 5;
	localparam int DRAIN_CYCLES  = 30;
	// Bits sent by the reset, NULL, FCT, N-Char, time-code and parity tests
	localparam int NUM_BITS      = 4 + 8 * 4 + 4 + (20 * 10 + 2 * 4) + (4 + 10 + 4 + 4)
		+ (8 * 10 + 2 * 4);
	localparam int MARGIN_CYCLES = 400;
	localparam int WATCHDOG_NS   = (NUM_BITS * BIT_CYCLES + MARGIN_CYCLES + RESET_CYCLES)
		* CLK_PERIOD;

	logic        negedge_clk;
	logic        rx_resetn;
	logic        rx_din;
	logic        rx_sin;
	token_info_t info;
	logic        info_strobe;

	integer seed;
	int     errors;
	string  test_name;

	// Encoder and reference model state
	data_byte_t  prev_body;
	logic        first_char;
	logic        esc_pend;
	logic        exp_par_err;
	logic        exp_got_null;
	token_info_t exp_q[$];
	token_info_t mon_exp;

	spw_token_detector u_dut (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.info        (info),
		.info_strobe (info_strobe)
	);

	initial
	begin
		negedge_clk = 1'b0;
		forever #(CLK_PERIOD / 2) negedge_clk = ~negedge_clk;
	end

	// --------------------
	// Data-strobe encoder
	// --------------------

	// Strobe toggles when the data value repeats
	task automatic send_bit(input logic v);
		if (v == rx_din)
			rx_sin = ~rx_sin;
		else
			rx_din = v;
		repeat (BIT_CYCLES) @(negedge negedge_clk);
	endtask

	task automatic send_char(input logic is_ctrl, input data_byte_t body, input logic corrupt);
		logic        par;
		logic        perr;
		token_kind_t kind;
		token_info_t exp;
		int          n;
		int          i;
		// Odd parity over previous body, this parity and this flag
		par = 1'b1 ^ (^prev_body) ^ is_ctrl;
		if (corrupt)
			par = ~par;
		perr = corrupt && !first_char;
		kind = TOK_NONE;
		if (!is_ctrl)
			kind = esc_pend ? TOK_TIME_CODE : TOK_NCHAR_DATA;
		else if (body[1:0] == CODE_FCT)
			kind = esc_pend ? TOK_NULL : TOK_FCT;
		else if (esc_pend)
			kind = TOK_ESC_ERR;
		else if (body[1:0] == CODE_EOP)
			kind = TOK_NCHAR_EOP;
		else if (body[1:0] == CODE_EEP)
			kind = TOK_NCHAR_EEP;
		esc_pend = is_ctrl && (body[1:0] == CODE_ESC) && !esc_pend;
		exp_par_err = exp_par_err || perr;
		if (kind == TOK_NULL)
			exp_got_null = 1'b1;
		// Lone ESC stays silent unless its parity failed
		if (kind != TOK_NONE || perr)
		begin
			exp.kind          = kind;
			exp.payload       = body;
			exp.parity_error  = exp_par_err;
			exp.got_bit       = 1'b1;
			exp.got_null      = exp_got_null;
			exp.got_time_code = (kind == TOK_TIME_CODE);
			exp.got_fct       = (kind == TOK_FCT);
			exp_q.push_back(exp);
		end
		n = is_ctrl ? CTRL_CHAR_BITS - 2 : DATA_CHAR_BITS - 2;
		send_bit(par);
		send_bit(is_ctrl);
		for (i = 0; i < n; i++)
			send_bit(body[i]);
		prev_body  = body;
		first_char = 1'b0;
	endtask

	task automatic send_ctrl(input ctrl_code_t code, input logic corrupt);
		send_char(1'b1, {6'b0, code}, corrupt);
	endtask

	task automatic send_data(input data_byte_t b, input logic corrupt);
		send_char(1'b0, b, corrupt);
	endtask

	// Waits for all queued reports and a few idle cycles for strays
	task automatic wait_for_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES)
		begin
			@(negedge negedge_clk);
			n++;
		end
		repeat (8) @(negedge negedge_clk);
		if (exp_q.size() != 0)
		begin
			$display("Missing info_strobe in %s: %0d expected reports never arrived",
				test_name, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	// --------------------
	// Monitor
	// --------------------

	always @(negedge negedge_clk)
	begin
		if (info_strobe)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected info_strobe in %s with info %h", test_name, info);
				errors++;
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				if (info !== mon_exp)
				begin
					$display("Mismatch in %s: expected %h, actual %h", test_name, mon_exp, info);
					errors++;
				end
			end
		end
	end

	// --------------------
	// Tests
	// --------------------

	task automatic reset_and_first_char();
		test_name = "reset";
		repeat (10) @(negedge negedge_clk);
		if (info !== '0)
		begin
			$display("Mismatch in %s: expected %h, actual %h", test_name, 16'h0000, info);
			errors++;
		end
		// No previous character, so wrong parity here is not an error
		send_ctrl(CODE_FCT, 1'b1);
		wait_for_drain();
	endtask

	task automatic null_stream();
		int k;
		test_name = "null_stream";
		for (k = 0; k < 4; k++)
		begin
			send_ctrl(CODE_ESC, 1'b0);
			send_ctrl(CODE_FCT, 1'b0);
		end
		wait_for_drain();
	endtask

	task automatic lone_fct();
		test_name = "lone_fct";
		send_ctrl(CODE_FCT, 1'b0);
		wait_for_drain();
	endtask

	task automatic nchar_stream();
		data_byte_t b;
		int         k;
		test_name = "nchars";
		for (k = 0; k < 20; k++)
		begin
			b = data_byte_t'($random(seed));
			send_data(b, 1'b0);
		end
		send_ctrl(CODE_EOP, 1'b0);
		send_ctrl(CODE_EEP, 1'b0);
		wait_for_drain();
	endtask

	task automatic time_code_and_esc_error();
		data_byte_t b;
		test_name = "time_code";
		b = data_byte_t'($random(seed));
		send_ctrl(CODE_ESC, 1'b0);
		send_data(b, 1'b0);
		send_ctrl(CODE_ESC, 1'b0);
		send_ctrl(CODE_EOP, 1'b0);
		wait_for_drain();
	endtask

	task automatic sticky_parity_error();
		int k;
		test_name = "parity";
		for (k = 0; k < 4; k++)
			send_data(data_byte_t'($random(seed)), 1'b0);
		// A bad ESC is still reported, then NULL and data keep the error
		send_ctrl(CODE_ESC, 1'b1);
		send_ctrl(CODE_FCT, 1'b0);
		for (k = 0; k < 4; k++)
			send_data(data_byte_t'($random(seed)), 1'b0);
		wait_for_drain();
	endtask

	// --------------------
	// Main sequence and watchdog
	// --------------------

	initial
	begin
		seed         = 94;
		errors       = 0;
		test_name    = "init";
		rx_resetn    = 1'b0;
		rx_din       = 1'b0;
		rx_sin       = 1'b0;
		prev_body    = '0;
		first_char   = 1'b1;
		esc_pend     = 1'b0;
		exp_par_err  = 1'b0;
		exp_got_null = 1'b0;
		repeat (RESET_CYCLES) @(negedge negedge_clk);
		rx_resetn = 1'b1;
		reset_and_first_char();
		null_stream();
		lone_fct();
		nchar_stream();
		time_code_and_esc_error();
		sticky_parity_error();
		errors = errors + u_dut.u_chk.fail_count;
		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout in %s, the tests did not finish in time", test_name);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== spw_token_detector_chk.sv ====
// Concurrent assertions for the token detector
// Reset, strobe spacing, parallel result strobes and the sticky
// parity error, bound to the top level

`timescale 1ns/1ps

module spw_token_detector_chk (
	input logic                          negedge_clk,
	input logic                          rx_resetn,
	input logic                          info_strobe,
	input spw_token_pkg::token_info_t    info,
	input spw_token_pkg::parity_result_t parity_res,
	input spw_token_pkg::token_result_t  token_res
);

	// Number of failed assertions
	int fail_count = 0;

	// No report while reset is held
	assert property (@(posedge negedge_clk) !rx_resetn |-> !info_strobe)
	else
	begin
		$error("info_strobe high during reset");
		fail_count++;
	end

	// Reports are single-cycle pulses
	assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		info_strobe |=> !info_strobe)
	else
	begin
		$error("info_strobe high on two consecutive cycles");
		fail_count++;
	end

	// Parity checker and classifier register the same character
	assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		parity_res.strobe == token_res.strobe)
	else
	begin
		$error("parity and token result strobes differ");
		fail_count++;
	end

	// Sticky until reset
	assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		info.parity_error |=> info.parity_error)
	else
	begin
		$error("parity_error cleared without reset");
		fail_count++;
	end

endmodule

bind spw_token_detector spw_token_detector_chk u_chk (
	.negedge_clk (negedge_clk),
	.rx_resetn   (rx_resetn),
	.info_strobe (info_strobe),
	.info        (info),
	.parity_res  (parity_w),
	.token_res   (token_w)
);

// ==== spw_token_detector.sv ====
// SpaceWire receive token detector, top level
// Bit recovery and framing feed the parity checker and token
// classifier side by side, the packer merges their results

`timescale 1ns/1ps

module spw_token_detector (
	input  logic                       negedge_clk,
	input  logic                       rx_resetn,
	input  logic                       rx_din,
	input  logic                       rx_sin,
	output spw_token_pkg::token_info_t info,
	output logic                       info_strobe
);

	import spw_char_pkg::*;
	import spw_token_pkg::*;

	rx_bit_t        bit_w;
	rx_char_t       char_w;
	parity_result_t parity_w;
	token_result_t  token_w;

	ds_bit_recovery u_recovery (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_out     (bit_w)
	);

	char_framer u_framer (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_in      (bit_w),
		.char_out    (char_w)
	);

	// The two checkers run in parallel on the same character
	char_parity_check u_parity (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.char_in     (char_w),
		.parity_out  (parity_w)
	);

	token_classifier u_classifier (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.char_in     (char_w),
		.token_out   (token_w)
	);

	token_info_pack u_pack (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_seen    (bit_w.strobe),
		.parity_in   (parity_w),
		.token_in    (token_w),
		.info        (info),
		.info_strobe (info_strobe)
	);

endmodule

// ==== token_info_pack.sv ====
// Status word packer
// Merges parity and token results into the info word, keeps the
// sticky parity error, got_bit and got_null flags

`timescale 1ns/1ps

module token_info_pack (
	input  logic                          negedge_clk,
	input  logic                          rx_resetn,
	input  logic                          bit_seen,
	input  spw_token_pkg::parity_result_t parity_in,
	input  spw_token_pkg::token_result_t  token_in,
	output spw_token_pkg::token_info_t    info,
	output logic                          info_strobe
);

	import spw_token_pkg::*;

	// Sticky flags
	logic parity_err_q;
	logic got_bit_q;
	logic got_null_q;

	logic both_valid;
	logic report;
	logic parity_err_next;
	logic got_null_next;

	assign both_valid      = parity_in.strobe && token_in.strobe;
	assign parity_err_next = parity_err_q || (both_valid && parity_in.error);
	assign got_null_next   = got_null_q || (both_valid && token_in.kind == TOK_NULL);

	// A lone ESC is silent unless its parity failed
	assign report = both_valid && (token_in.kind != TOK_NONE || parity_in.error);

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			parity_err_q <= 1'b0;
			got_bit_q    <= 1'b0;
			got_null_q   <= 1'b0;
			info_strobe  <= 1'b0;
			info         <= '0;
		end
		else
		begin
			got_bit_q    <= got_bit_q || bit_seen;
			parity_err_q <= parity_err_next;
			got_null_q   <= got_null_next;
			info_strobe  <= report;

			if (report)
			begin
				info.kind          <= token_in.kind;
				info.payload       <= token_in.payload;
				info.parity_error  <= parity_err_next;
				info.got_bit       <= got_bit_q || bit_seen;
				info.got_null      <= got_null_next;
				info.got_time_code <= (token_in.kind == TOK_TIME_CODE);
				info.got_fct       <= (token_in.kind == TOK_FCT);
			end
		end
	end

endmodule

// ==== token_classifier.sv ====
// Token classifier
// Decodes each framed character with one character of escape
// history into a token kind and payload

`timescale 1ns/1ps

module token_classifier (
	input  logic                         negedge_clk,
	input  logic                         rx_resetn,
	input  spw_char_pkg::rx_char_t       char_in,
	output spw_token_pkg::token_result_t token_out
);

	import spw_char_pkg::*;
	import spw_token_pkg::*;

	// Previous character was a lone ESC
	logic esc_pending;

	ctrl_code_t  code;
	token_kind_t kind_next;
	logic        pending_next;

	assign code = char_in.payload[1:0];

	// --------------------
	// Decode
	// --------------------

	always_comb
	begin
		kind_next    = TOK_NONE;
		pending_next = 1'b0;

		if (char_in.is_ctrl)
		begin
			case (code)
				CODE_FCT: kind_next = esc_pending ? TOK_NULL : TOK_FCT;
				CODE_EOP: kind_next = esc_pending ? TOK_ESC_ERR : TOK_NCHAR_EOP;
				CODE_EEP: kind_next = esc_pending ? TOK_ESC_ERR : TOK_NCHAR_EEP;
				CODE_ESC:
				begin
					// ESC ESC is an error, a lone ESC waits for the next char
					if (esc_pending)
						kind_next = TOK_ESC_ERR;
					else
						pending_next = 1'b1;
				end
				default: kind_next = TOK_NONE;
			endcase
		end
		else
		begin
			kind_next = esc_pending ? TOK_TIME_CODE : TOK_NCHAR_DATA;
		end
	end

	// Result register, one strobe per character
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			esc_pending <= 1'b0;
			token_out   <= '0;
		end
		else
		begin
			token_out.strobe <= char_in.strobe;
			if (char_in.strobe)
			begin
				esc_pending       <= pending_next;
				token_out.kind    <= kind_next;
				token_out.payload <= char_in.payload;
			end
		end
	end

endmodule

// ==== char_parity_check.sv ====
// Odd parity check across consecutive characters
// Parity covers the previous body bits plus the current
// parity and flag bits

`timescale 1ns/1ps

module char_parity_check (
	input  logic                         negedge_clk,
	input  logic                         rx_resetn,
	input  spw_char_pkg::rx_char_t       char_in,
	output spw_token_pkg::parity_result_t parity_out
);

	import spw_char_pkg::*;

	// Body of the previous character, zero above the code for control
	data_byte_t prev_body;

	// No previous character yet
	logic first_q;

	logic par_ok;

	assign par_ok = ^{prev_body, char_in.parity, char_in.is_ctrl};

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			first_q    <= 1'b1;
			parity_out <= '0;
		end
		else
		begin
			parity_out.strobe <= char_in.strobe;
			if (char_in.strobe)
			begin
				parity_out.error <= !first_q && !par_ok;
				first_q          <= 1'b0;
			end
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (char_in.strobe)
			prev_body <= char_in.payload;
	end

endmodule

// ==== char_framer.sv ====
// Character framer
// Collects recovered bits into parity, flag and body, using the
// flag to pick a 2-bit control or 8-bit data body, LSB first

`timescale 1ns/1ps

module char_framer (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  spw_char_pkg::rx_bit_t  bit_in,
	output spw_char_pkg::rx_char_t char_out
);

	import spw_char_pkg::*;

	typedef enum logic [1:0] {
		FRAME_PARITY,
		FRAME_FLAG,
		FRAME_BODY
	} frame_state_t;

	frame_state_t state;
	body_idx_t    bit_cnt;
	body_idx_t    body_last;

	// Character under assembly
	logic       par_q;
	logic       flag_q;
	data_byte_t body_q;
	data_byte_t body_next;

	logic char_done;

	// Body holds CTRL_CHAR_BITS-2 or DATA_CHAR_BITS-2 bits
	always_comb
	begin
		body_last = flag_q ? body_idx_t'(CTRL_CHAR_BITS - 3) : body_idx_t'(DATA_CHAR_BITS - 3);
		body_next = body_q;
		body_next[bit_cnt] = bit_in.value;
	end

	assign char_done = bit_in.strobe && (state == FRAME_BODY) && (bit_cnt == body_last);

	// --------------------
	// Framing FSM
	// --------------------

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state   <= FRAME_PARITY;
			bit_cnt <= '0;
		end
		else if (bit_in.strobe)
		begin
			case (state)
				FRAME_PARITY:
				begin
					state <= FRAME_FLAG;
				end
				FRAME_FLAG:
				begin
					bit_cnt <= '0;
					state   <= FRAME_BODY;
				end
				FRAME_BODY:
				begin
					if (bit_cnt == body_last)
						state <= FRAME_PARITY;
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default:
				begin
					state <= FRAME_PARITY;
				end
			endcase
		end
	end

	// Character contents
	always_ff @(posedge negedge_clk)
	begin
		if (bit_in.strobe)
		begin
			if (state == FRAME_PARITY)
				par_q <= bit_in.value;
			if (state == FRAME_FLAG)
			begin
				flag_q <= bit_in.value;
				// Upper bits stay zero for control characters
				body_q <= '0;
			end
			if (state == FRAME_BODY)
				body_q <= body_next;
		end
	end

	// --------------------
	// Output register
	// --------------------

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			char_out <= '0;
		end
		else
		begin
			char_out.strobe <= char_done;
			if (char_done)
			begin
				char_out.parity  <= par_q;
				char_out.is_ctrl <= flag_q;
				char_out.payload <= body_next;
			end
		end
	end

endmodule

// ==== ds_bit_recovery.sv ====
// Data-strobe bit recovery
// Synchronises the data and strobe lines and emits one bit
// strobe per transition on either line

`timescale 1ns/1ps

module ds_bit_recovery (
	input  logic                  negedge_clk,
	input  logic                  rx_resetn,
	input  logic                  rx_din,
	input  logic                  rx_sin,
	output spw_char_pkg::rx_bit_t bit_out
);

	// Two-stage synchronisers
	logic din_s1;
	logic din_s2;
	logic sin_s1;
	logic sin_s2;

	// Last seen D xor S, toggles once per link bit
	logic ds_xor_q;
	logic ds_xor;

	assign ds_xor = din_s2 ^ sin_s2;

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_s1   <= 1'b0;
			din_s2   <= 1'b0;
			sin_s1   <= 1'b0;
			sin_s2   <= 1'b0;
			ds_xor_q <= 1'b0;
			bit_out  <= '0;
		end
		else
		begin
			din_s1 <= rx_din;
			din_s2 <= din_s1;
			sin_s1 <= rx_sin;
			sin_s2 <= sin_s1;

			ds_xor_q <= ds_xor;

			// A change of D xor S marks a new bit, value is on D
			bit_out.strobe <= ds_xor ^ ds_xor_q;
			bit_out.value  <= din_s2;
		end
	end

endmodule

// ==== spw_token_pkg.sv ====
// Token level result definitions
// Token kinds, per-character parity and token results and
// the packed status word reported at the top level

package spw_token_pkg;

	// Token kind carried in results and in the status word
	typedef logic [2:0] token_kind_t;

	localparam token_kind_t TOK_NONE       = 3'd0;
	localparam token_kind_t TOK_FCT        = 3'd1;
	localparam token_kind_t TOK_NULL       = 3'd2;
	localparam token_kind_t TOK_NCHAR_DATA = 3'd3;
	localparam token_kind_t TOK_NCHAR_EOP  = 3'd4;
	localparam token_kind_t TOK_NCHAR_EEP  = 3'd5;
	localparam token_kind_t TOK_TIME_CODE  = 3'd6;
	// ESC followed by ESC, EOP or EEP
	localparam token_kind_t TOK_ESC_ERR    = 3'd7;

	// --------------------
	// Per-character results
	// --------------------

	typedef struct packed {
		logic strobe;
		logic error;
	} parity_result_t;

	typedef struct packed {
		logic                     strobe;
		token_kind_t              kind;
		spw_char_pkg::data_byte_t payload;
	} token_result_t;

	// --------------------
	// Status word, 16 bits
	// --------------------

	typedef struct packed {
		token_kind_t              kind;
		spw_char_pkg::data_byte_t payload;
		logic                     parity_error;
		logic                     got_bit;
		logic                     got_null;
		logic                     got_time_code;
		logic                     got_fct;
	} token_info_t;

endpackage

// ==== spw_char_pkg.sv ====
// SpaceWire link character definitions
// Control codes, character lengths and bit and character
// carriers shared by the recovery, framing and checking stages

package spw_char_pkg;

	// --------------------
	// Widths with a meaning
	// --------------------

	// Control code in the two body bits of a control character
	typedef logic [1:0] ctrl_code_t;

	// N-Char or time-code byte
	typedef logic [7:0] data_byte_t;

	// Index of a body bit within a character
	typedef logic [2:0] body_idx_t;

	// --------------------
	// Control codes
	// --------------------

	localparam ctrl_code_t CODE_FCT = 2'd0;
	localparam ctrl_code_t CODE_EOP = 2'd1;
	localparam ctrl_code_t CODE_EEP = 2'd2;
	localparam ctrl_code_t CODE_ESC = 2'd3;

	// Full length including parity and flag
	localparam int CTRL_CHAR_BITS = 4;
	localparam int DATA_CHAR_BITS = 10;

	// --------------------
	// Carriers
	// --------------------

	// One recovered link bit
	typedef struct packed {
		logic strobe;
		logic value;
	} rx_bit_t;

	// One framed character, control code in payload[1:0] when is_ctrl
	typedef struct packed {
		logic       strobe;
		logic       parity;
		logic       is_ctrl;
		data_byte_t payload;
	} rx_char_t;

endpackage
